// File: verif/decode_exec_golden.txt
// instr stall, wb_valid wb_dest wb_data, mem_read mem_write mem_addr mem_wdata, br_taken br_target
// One row per cycle in hex; stalled and squashed rows expect no event; FFFFFFFF ends the stream
08200005 0 1 01 00000005 0 0 00000000 00000000 0 00000000
0840FFFD 0 1 02 FFFFFFFD 0 0 00000000 00000000 0 00000000
0C62F0F0 0 1 03 0000F0F0 0 0 00000000 00000000 0 00000000
10818000 0 1 04 00008005 0 0 00000000 00000000 0 00000000
04A11000 0 1 05 00000002 0 0 00000000 00000000 0 00000000
04C32001 0 1 06 000070EB 0 0 00000000 00000000 0 00000000
04E61002 0 1 07 000070E9 0 0 00000000 00000000 0 00000000
05013803 0 1 08 000070ED 0 0 00000000 00000000 0 00000000
05283004 0 1 09 00000006 0 0 00000000 00000000 0 00000000
05420805 0 1 0A 00000001 0 0 00000000 00000000 0 00000000
05614806 0 1 0B 00000140 0 0 00000000 00000000 0 00000000
05825007 0 1 0C 7FFFFFFE 0 0 00000000 00000000 0 00000000
05A06008 0 1 0D 7FFFFFFE 0 0 00000000 00000000 0 00000000
08000006 0 1 00 00000006 0 0 00000000 00000000 0 00000000
09C00001 0 1 0E 00000001 0 0 00000000 00000000 0 00000000
18810008 0 0 00 00000000 0 1 0000000D 00008005 0 00000000
14A20010 0 0 00 00000000 1 0 0000000D 00000000 0 00000000
09E00100 0 1 0F 00000100 0 0 00000000 00000000 0 00000000
19EFFFFC 0 0 00 00000000 0 1 000000FC 00000100 0 00000000
1C210003 0 0 00 00000000 0 0 00000000 00000000 1 0000005C
0A000BAD 0 0 00 00000000 0 0 00000000 00000000 0 00000000
2041FFFE 0 0 00 00000000 0 0 00000000 00000000 1 00000058
0A000BAD 0 0 00 00000000 0 0 00000000 00000000 0 00000000
1C410010 0 0 00 00000000 0 0 00000000 00000000 0 00000000
20210004 0 0 00 00000000 0 0 00000000 00000000 0 00000000
24000004 0 0 00 00000000 0 0 00000000 00000000 1 00000074
0A000BAD 0 0 00 00000000 0 0 00000000 00000000 0 00000000
12300000 0 1 11 00000000 0 0 00000000 00000000 0 00000000
0A410010 1 0 00 00000000 0 0 00000000 00000000 0 00000000
0A410010 0 1 12 00000015 0 0 00000000 00000000 0 00000000
06729000 0 1 13 0000002A 0 0 00000000 00000000 0 00000000
06930801 1 0 00 00000000 0 0 00000000 00000000 0 00000000
06930801 0 1 14 00000025 0 0 00000000 00000000 0 00000000
FFFFFFFF 0 0 00 00000000 0 0 00000000 00000000 0 00000000

// File: compile.f
hw/cpu_pkg.sv
hw/id_ex_if.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/id_ex_reg.sv
hw/exe_stage.sv
hw/decode_exec_top.sv
verif/clk_gen.sv
verif/tb_decode_exec.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the decode-to-execute testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_decode_exec -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if grep -q "All checks passed" <<< "$output"; then
	exit 0
fi
exit 1

// File: verif/tb_decode_exec.sv
// Testbench for the decode-to-execute slice, driven and checked from the golden stream
`timescale 1ns/10ps

module tb_decode_exec import cpu_pkg::*;
();

	localparam int max_rows   = 64;
	localparam int row_words  = 11;
	localparam int reset_slot = max_rows;

	logic                  clk;
	logic                  rst_n;
	logic [xlen_w-1:0]     instr;
	logic [xlen_w-1:0]     pc;
	logic                  stall;
	logic                  wb_valid;
	logic [reg_addr_w-1:0] wb_dest;
	logic [xlen_w-1:0]     wb_data;
	logic                  mem_read;
	logic                  mem_write;
	logic [xlen_w-1:0]     mem_addr;
	logic [xlen_w-1:0]     mem_wdata;
	logic                  branch_taken;
	logic [xlen_w-1:0]     branch_target;

	logic [31:0] golden [max_rows*row_words];
	bit          row_bad [max_rows+1];
	int          num_rows;
	int          cur_slot;
	int          check_count;
	int          error_count;
	bit          rows_ready;

	clk_gen i_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	decode_exec_top i_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr         (instr),
		.pc            (pc),
		.stall         (stall),
		.wb_valid      (wb_valid),
		.wb_dest       (wb_dest),
		.wb_data       (wb_data),
		.mem_read      (mem_read),
		.mem_write     (mem_write),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	task automatic report_mismatch(
		input string       name,
		input logic [31:0] got,
		input logic [31:0] exp
	);
		$display("MISMATCH %s: got %h, expected %h", name, got, exp);
		error_count++;
		row_bad[cur_slot] = 1'b1;
	endtask

	task automatic check_wb(
		input logic                  exp_valid,
		input logic [reg_addr_w-1:0] exp_dest,
		input logic [xlen_w-1:0]     exp_data
	);
		check_count++;
		if (wb_valid !== exp_valid)
			report_mismatch("wb_valid", 32'(wb_valid), 32'(exp_valid));
		else if (exp_valid)
		begin
			if (wb_dest !== exp_dest)
				report_mismatch("wb_dest", 32'(wb_dest), 32'(exp_dest));
			if (wb_data !== exp_data)
				report_mismatch("wb_data", wb_data, exp_data);
		end
	endtask

	task automatic check_mem(
		input logic              exp_read,
		input logic              exp_write,
		input logic [xlen_w-1:0] exp_addr,
		input logic [xlen_w-1:0] exp_wdata
	);
		check_count++;
		if (mem_read !== exp_read)
			report_mismatch("mem_read", 32'(mem_read), 32'(exp_read));
		if (mem_write !== exp_write)
			report_mismatch("mem_write", 32'(mem_write), 32'(exp_write));
		if ((exp_read || exp_write) && (mem_addr !== exp_addr))
			report_mismatch("mem_addr", mem_addr, exp_addr);
		if (exp_write && (mem_wdata !== exp_wdata))
			report_mismatch("mem_wdata", mem_wdata, exp_wdata);
	endtask

	task automatic check_branch(
		input logic              exp_taken,
		input logic [xlen_w-1:0] exp_target
	);
		check_count++;
		if (branch_taken !== exp_taken)
			report_mismatch("branch_taken", 32'(branch_taken), 32'(exp_taken));
		else if (exp_taken && (branch_target !== exp_target))
			report_mismatch("branch_target", branch_target, exp_target);
	endtask

	// Upstream redirects two rows after a taken branch and holds its PC on a stall
	task automatic drive_row(input int k);
		int base;
		base = k * row_words;
		if (k >= num_rows)
		begin
			instr = '0;
			stall = 1'b0;
		end
		else
		begin
			if (k >= 2 && golden[base-2*row_words+9][0])
				pc = golden[base-2*row_words+10];
			else if (k >= 1 && !golden[base-row_words+1][0])
				pc = pc + 32'd4;
			instr = golden[base];
			stall = golden[base+1][0];
		end
	endtask

	initial
	begin
		int base;
		bit found;
		instr       = '0;
		pc          = '0;
		stall       = 1'b0;
		check_count = 0;
		error_count = 0;
		num_rows    = 0;
		cur_slot    = reset_slot;
		rows_ready  = 1'b0;
		found       = 1'b0;
		$readmemh("verif/decode_exec_golden.txt", golden);
		// Stream ends at the all-ones instruction
		while (!found && num_rows < max_rows)
		begin
			if (golden[num_rows*row_words] === 32'hffffffff)
				found = 1'b1;
			else
				num_rows++;
		end
		if (!found)
		begin
			$display("Golden file has no end marker row");
			error_count++;
		end
		rows_ready = 1'b1;

		// Outputs cleared by the first reset edge
		@(posedge clk);
		@(negedge clk);
		check_wb(1'b0, '0, '0);
		check_mem(1'b0, 1'b0, '0, '0);
		check_branch(1'b0, '0);

		@(posedge rst_n);
		for (int k = 0; k < num_rows + 2; k++)
		begin
			@(negedge clk);
			if (k < 2)
			begin
				// Nothing may be valid before the first row arrives
				cur_slot = reset_slot;
				check_wb(1'b0, '0, '0);
				check_mem(1'b0, 1'b0, '0, '0);
				if (k == 0)
					check_branch(1'b0, '0);
				else
					$display("reset: %s", row_bad[reset_slot] ? "error" : "ok");
			end
			else
			begin
				base     = (k - 2) * row_words;
				cur_slot = k - 2;
				check_wb(golden[base+2][0], golden[base+3][reg_addr_w-1:0], golden[base+4]);
				check_mem(golden[base+5][0], golden[base+6][0], golden[base+7], golden[base+8]);
				$display("row %0d: %s", k - 2, row_bad[k-2] ? "error" : "ok");
			end
			if (k >= 1 && k <= num_rows)
			begin
				base     = (k - 1) * row_words;
				cur_slot = k - 1;
				check_branch(golden[base+9][0], golden[base+10]);
			end
			drive_row(k);
		end

		$display("rows %0d, checks %0d, errors %0d", num_rows, check_count, error_count);
		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		int cycles;
		cycles = 0;
		wait (rows_ready);
		while (cycles < num_rows + 20)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not end within %0d cycles", cycles);
		$display("Checks failed");
		$finish;
	end

endmodule

// File: verif/clk_gen.sv
// Clock and reset generator for the testbench: 8 ns clock, reset held low for two cycles
`timescale 1ns/10ps

module clk_gen
(
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Released on a falling edge, away from the capturing edge
	initial
	begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// File: hw/decode_exec_top.sv
// Decode-to-execute top: decoder, register file, ID/EX register and execute stage
`timescale 1ns/10ps

module decode_exec_top import cpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [xlen_w-1:0]     instr,
	input  logic [xlen_w-1:0]     pc,
	input  logic                  stall,
	output logic                  wb_valid,
	output logic [reg_addr_w-1:0] wb_dest,
	output logic [xlen_w-1:0]     wb_data,
	output logic                  mem_read,
	output logic                  mem_write,
	output logic [xlen_w-1:0]     mem_addr,
	output logic [xlen_w-1:0]     mem_wdata,
	output logic                  branch_taken,
	output logic [xlen_w-1:0]     branch_target
);

	logic [reg_addr_w-1:0] rs_addr;
	logic [reg_addr_w-1:0] rt_addr;
	logic [reg_addr_w-1:0] dest;
	logic [xlen_w-1:0]     imm;
	logic [xlen_w-1:0]     rd_data1;
	logic [xlen_w-1:0]     rd_data2;
	exe_cmd_t              exe_cmd;
	br_type_t              br_type;
	logic                  wb_en;
	logic                  mem_r_en;
	logic                  mem_w_en;
	logic                  use_imm;

	id_ex_if id_ex ();

	instr_decoder i_decoder (
		.instr    (instr),
		.rs_addr  (rs_addr),
		.rt_addr  (rt_addr),
		.dest     (dest),
		.imm      (imm),
		.exe_cmd  (exe_cmd),
		.br_type  (br_type),
		.wb_en    (wb_en),
		.mem_r_en (mem_r_en),
		.mem_w_en (mem_w_en),
		.use_imm  (use_imm)
	);

	// Write port is fed by the execute result register
	reg_file i_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_addr1 (rs_addr),
		.rd_addr2 (rt_addr),
		.wr_en    (wb_valid),
		.wr_addr  (wb_dest),
		.wr_data  (wb_data),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2)
	);

	id_ex_reg i_id_ex_reg (
		.clk          (clk),
		.rst_n        (rst_n),
		.stall        (stall),
		.branch_taken (branch_taken),
		.dest         (dest),
		.rs_addr      (rs_addr),
		.rt_addr      (rt_addr),
		.rd_data1     (rd_data1),
		.rd_data2     (rd_data2),
		.imm          (imm),
		.use_imm      (use_imm),
		.pc           (pc),
		.wb_en        (wb_en),
		.mem_r_en     (mem_r_en),
		.mem_w_en     (mem_w_en),
		.br_type      (br_type),
		.exe_cmd      (exe_cmd),
		.id_ex        (id_ex.source)
	);

	exe_stage i_exe (
		.clk           (clk),
		.rst_n         (rst_n),
		.id_ex         (id_ex.sink),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.wb_valid      (wb_valid),
		.wb_dest       (wb_dest),
		.wb_data       (wb_data),
		.mem_read      (mem_read),
		.mem_write     (mem_write),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata)
	);

endmodule

// File: hw/exe_stage.sv
// Execute stage: operand forwarding, ALU, branch resolution and the result register
`timescale 1ns/10ps

module exe_stage import cpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	id_ex_if.sink                 id_ex,
	output logic                  branch_taken,
	output logic [xlen_w-1:0]     branch_target,
	output logic                  wb_valid,
	output logic [reg_addr_w-1:0] wb_dest,
	output logic [xlen_w-1:0]     wb_data,
	output logic                  mem_read,
	output logic                  mem_write,
	output logic [xlen_w-1:0]     mem_addr,
	output logic [xlen_w-1:0]     mem_wdata
);

	logic              fwd_rs;
	logic              fwd_rt;
	logic [xlen_w-1:0] op_a;
	logic [xlen_w-1:0] op_rt;
	logic [xlen_w-1:0] alu_b;
	logic [xlen_w-1:0] alu_res;

	// --------------------------------------------------
	// Forwarding from the result register
	// --------------------------------------------------
	assign fwd_rs = wb_valid && (id_ex.rs_addr != '0) && (id_ex.rs_addr == wb_dest);
	assign fwd_rt = wb_valid && (id_ex.rt_addr != '0) && (id_ex.rt_addr == wb_dest);

	assign op_a  = fwd_rs ? wb_data : id_ex.readdata1;
	assign op_rt = fwd_rt ? wb_data : id_ex.readdata2;
	// A store keeps its offset in imm even though rt is live
	assign alu_b = (fwd_rt && !id_ex.mem_w_en) ? wb_data : id_ex.imm;

	always_comb
	begin
		case (id_ex.exe_cmd)
			exe_add:    alu_res = op_a + alu_b;
			exe_sub:    alu_res = op_a - alu_b;
			exe_and:    alu_res = op_a & alu_b;
			exe_or:     alu_res = op_a | alu_b;
			exe_xor:    alu_res = op_a ^ alu_b;
			exe_slt:    alu_res = {{(xlen_w-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
			exe_sll:    alu_res = op_a << alu_b[shamt_w-1:0];
			exe_srl:    alu_res = op_a >> alu_b[shamt_w-1:0];
			exe_pass_b: alu_res = alu_b;
			default:    alu_res = '0;
		endcase
	end

	// --------------------------------------------------
	// Branch resolution
	// --------------------------------------------------
	always_comb
	begin
		case (id_ex.br_type)
			br_eq:     branch_taken = (op_a == op_rt);
			br_ne:     branch_taken = (op_a != op_rt);
			br_always: branch_taken = 1'b1;
			default:   branch_taken = 1'b0;
		endcase
	end

	assign branch_target = id_ex.pc + pc_step + (id_ex.imm << 2);

	// --------------------------------------------------
	// Result register
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wb_valid  <= 1'b0;
			mem_read  <= 1'b0;
			mem_write <= 1'b0;
		end
		else
		begin
			wb_valid  <= id_ex.wb_en;
			mem_read  <= id_ex.mem_r_en;
			mem_write <= id_ex.mem_w_en;
		end
	end

	always_ff @(posedge clk)
	begin
		wb_dest   <= id_ex.dest;
		wb_data   <= alu_res;
		mem_addr  <= alu_res;
		mem_wdata <= op_rt;
	end

endmodule

// File: hw/id_ex_reg.sv
// ID/EX pipeline register: latches the decoded bundle, bubble on reset, branch or stall
`timescale 1ns/10ps

module id_ex_reg import cpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall,
	input  logic                  branch_taken,
	input  logic [reg_addr_w-1:0] dest,
	input  logic [reg_addr_w-1:0] rs_addr,
	input  logic [reg_addr_w-1:0] rt_addr,
	input  logic [xlen_w-1:0]     rd_data1,
	input  logic [xlen_w-1:0]     rd_data2,
	input  logic [xlen_w-1:0]     imm,
	input  logic                  use_imm,
	input  logic [xlen_w-1:0]     pc,
	input  logic                  wb_en,
	input  logic                  mem_r_en,
	input  logic                  mem_w_en,
	input  br_type_t              br_type,
	input  exe_cmd_t              exe_cmd,
	id_ex_if.source               id_ex
);

	always_ff @(posedge clk)
	begin
		if (!rst_n || branch_taken || stall)
		begin
			// Bubble
			id_ex.dest      <= '0;
			id_ex.rs_addr   <= '0;
			id_ex.rt_addr   <= '0;
			id_ex.readdata1 <= '0;
			id_ex.readdata2 <= '0;
			id_ex.imm       <= '0;
			id_ex.pc        <= '0;
			id_ex.wb_en     <= 1'b0;
			id_ex.mem_r_en  <= 1'b0;
			id_ex.mem_w_en  <= 1'b0;
			id_ex.br_type   <= br_none;
			id_ex.exe_cmd   <= exe_add;
		end
		else
		begin
			id_ex.dest      <= dest;
			id_ex.rs_addr   <= rs_addr;
			id_ex.rt_addr   <= rt_addr;
			id_ex.readdata1 <= rd_data1;
			id_ex.readdata2 <= rd_data2;
			// Register ops carry rt's value in the imm slot
			id_ex.imm       <= use_imm ? imm : rd_data2;
			id_ex.pc        <= pc;
			id_ex.wb_en     <= wb_en;
			id_ex.mem_r_en  <= mem_r_en;
			id_ex.mem_w_en  <= mem_w_en;
			id_ex.br_type   <= br_type;
			id_ex.exe_cmd   <= exe_cmd;
		end
	end

endmodule

// File: hw/reg_file.sv
// Register file: 32 x 32, two combinational reads, one write, write-through bypass
`timescale 1ns/10ps

module reg_file import cpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [reg_addr_w-1:0] rd_addr1,
	input  logic [reg_addr_w-1:0] rd_addr2,
	input  logic                  wr_en,
	input  logic [reg_addr_w-1:0] wr_addr,
	input  logic [xlen_w-1:0]     wr_data,
	output logic [xlen_w-1:0]     rd_data1,
	output logic [xlen_w-1:0]     rd_data2
);

	logic [xlen_w-1:0] regs [reg_count];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end
		else if (wr_en && (wr_addr != '0))
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Register 0 wins over the bypass
	assign rd_data1 = (rd_addr1 == '0) ? '0 :
		(wr_en && (wr_addr == rd_addr1)) ? wr_data : regs[rd_addr1];
	assign rd_data2 = (rd_addr2 == '0) ? '0 :
		(wr_en && (wr_addr == rd_addr2)) ? wr_data : regs[rd_addr2];

endmodule

// File: hw/instr_decoder.sv
// Instruction decoder: field split, control generation and immediate extension
`timescale 1ns/10ps

module instr_decoder import cpu_pkg::*;
(
	input  logic [xlen_w-1:0]     instr,
	output logic [reg_addr_w-1:0] rs_addr,
	output logic [reg_addr_w-1:0] rt_addr,
	output logic [reg_addr_w-1:0] dest,
	output logic [xlen_w-1:0]     imm,
	output exe_cmd_t              exe_cmd,
	output br_type_t              br_type,
	output logic                  wb_en,
	output logic                  mem_r_en,
	output logic                  mem_w_en,
	output logic                  use_imm
);

	opcode_t               opcode;
	logic [reg_addr_w-1:0] rd_f;
	logic [reg_addr_w-1:0] rs_f;
	logic [reg_addr_w-1:0] rt_f;
	logic [funct_w-1:0]    funct;
	logic [xlen_w-1:0]     imm_sext;
	logic [xlen_w-1:0]     imm_zext;

	assign opcode = opcode_t'(instr[op_lsb +: opcode_w]);
	assign rd_f   = instr[rd_lsb +: reg_addr_w];
	assign rs_f   = instr[rs_lsb +: reg_addr_w];
	assign rt_f   = instr[rt_lsb +: reg_addr_w];
	assign funct  = instr[funct_w-1:0];

	assign imm_sext = {{(xlen_w-imm_w){instr[imm_w-1]}}, instr[imm_w-1:0]};
	assign imm_zext = {{(xlen_w-imm_w){1'b0}}, instr[imm_w-1:0]};

	// rt overlaps imm16, so stores and compares read their second register from rd
	always_comb
	begin
		rs_addr  = '0;
		rt_addr  = '0;
		dest     = '0;
		imm      = imm_sext;
		exe_cmd  = exe_add;
		br_type  = br_none;
		wb_en    = 1'b0;
		mem_r_en = 1'b0;
		mem_w_en = 1'b0;
		use_imm  = 1'b0;
		case (opcode)
			op_alu:
			begin
				if (funct <= exe_pass_b)
				begin
					rs_addr = rs_f;
					rt_addr = rt_f;
					dest    = rd_f;
					exe_cmd = exe_cmd_t'(funct);
					wb_en   = 1'b1;
				end
			end
			op_addi, op_andi, op_ori:
			begin
				rs_addr = rs_f;
				dest    = rd_f;
				wb_en   = 1'b1;
				use_imm = 1'b1;
				if (opcode == op_andi)
				begin
					exe_cmd = exe_and;
					imm     = imm_zext;
				end
				else if (opcode == op_ori)
				begin
					exe_cmd = exe_or;
					imm     = imm_zext;
				end
			end
			op_lw:
			begin
				rs_addr  = rs_f;
				mem_r_en = 1'b1;
				use_imm  = 1'b1;
			end
			op_sw:
			begin
				rs_addr  = rs_f;
				rt_addr  = rd_f;
				mem_w_en = 1'b1;
				use_imm  = 1'b1;
			end
			op_beq, op_bne:
			begin
				rs_addr = rs_f;
				rt_addr = rd_f;
				use_imm = 1'b1;
				br_type = (opcode == op_beq) ? br_eq : br_ne;
			end
			op_jmp:
			begin
				use_imm = 1'b1;
				br_type = br_always;
			end
			default:
			begin
				// op_nop and unknown opcodes keep the idle defaults
			end
		endcase
	end

endmodule

// File: hw/id_ex_if.sv
// ID/EX bundle: decoded controls, operands and PC passed from decode into execute
`timescale 1ns/10ps

interface id_ex_if import cpu_pkg::*; ();

	logic                  wb_en;
	logic                  mem_r_en;
	logic                  mem_w_en;
	br_type_t              br_type;
	exe_cmd_t              exe_cmd;
	logic [reg_addr_w-1:0] dest;
	logic [reg_addr_w-1:0] rs_addr;
	logic [reg_addr_w-1:0] rt_addr;
	logic [xlen_w-1:0]     readdata1;
	logic [xlen_w-1:0]     readdata2;
	logic [xlen_w-1:0]     imm;
	logic [xlen_w-1:0]     pc;

	modport source (
		output wb_en, mem_r_en, mem_w_en, br_type, exe_cmd,
		output dest, rs_addr, rt_addr, readdata1, readdata2, imm, pc
	);

	modport sink (
		input wb_en, mem_r_en, mem_w_en, br_type, exe_cmd,
		input dest, rs_addr, rt_addr, readdata1, readdata2, imm, pc
	);

endinterface

// File: hw/cpu_pkg.sv
// CPU package: field widths, instruction layout and the opcode, ALU and branch encodings
package cpu_pkg;

	// --------------------------------------------------
	// Widths
	// --------------------------------------------------
	localparam int xlen_w     = 32;
	localparam int reg_addr_w = 5;
	localparam int reg_count  = 32;
	localparam int opcode_w   = 6;
	localparam int funct_w    = 4;
	localparam int imm_w      = 16;
	localparam int shamt_w    = 5;

	// Field positions in the instruction word
	localparam int op_lsb = 26;
	localparam int rd_lsb = 21;
	localparam int rs_lsb = 16;
	localparam int rt_lsb = 11;

	// Sequential PC increment
	localparam int pc_step = 4;

	// --------------------------------------------------
	// Encodings
	// --------------------------------------------------
	typedef enum logic [opcode_w-1:0] {
		op_nop  = 6'h00,
		op_alu  = 6'h01,
		op_addi = 6'h02,
		op_andi = 6'h03,
		op_ori  = 6'h04,
		op_lw   = 6'h05,
		op_sw   = 6'h06,
		op_beq  = 6'h07,
		op_bne  = 6'h08,
		op_jmp  = 6'h09
	} opcode_t;

	// Also the function field of op_alu
	typedef enum logic [funct_w-1:0] {
		exe_add    = 4'h0,
		exe_sub    = 4'h1,
		exe_and    = 4'h2,
		exe_or     = 4'h3,
		exe_xor    = 4'h4,
		exe_slt    = 4'h5,
		exe_sll    = 4'h6,
		exe_srl    = 4'h7,
		exe_pass_b = 4'h8
	} exe_cmd_t;

	typedef enum logic [1:0] {
		br_none   = 2'b00,
		br_eq     = 2'b01,
		br_ne     = 2'b10,
		br_always = 2'b11
	} br_type_t;

endpackage
